// ==== source/dram_cmd_pkg.sv ====
// DDR4 command front end shared definitions
// Widths, latencies, address map types, request/command structs and FSM states
`default_nettype none

package dram_cmd_pkg;

    // Address and bus widths
    localparam int PADDR_BITS     = 19;
    localparam int COL_BITS       = 4;
    localparam int BA_BITS        = 2;
    localparam int BG_BITS        = 2;
    localparam int ROW_BITS       = 8;
    localparam int NUM_BANKS      = 16;  // 4 bank groups x 4 banks
    localparam int DRAM_ADDR_BITS = 17;
    localparam int DATA_BITS      = 64;
    localparam int QUEUE_DEPTH    = 16;

    // DRAM timing in clock cycles
    localparam int PRECHARGE_LATENCY  = 5;
    localparam int ACTIVATION_LATENCY = 8;
    localparam int MAX_LATENCY = (ACTIVATION_LATENCY > PRECHARGE_LATENCY) ?
                                 ACTIVATION_LATENCY : PRECHARGE_LATENCY;
    localparam int WAIT_BITS   = $clog2(MAX_LATENCY);  // Counter loads latency minus one
    localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);

    // RAS, CAS, WE in the top three address bits
    localparam logic [2:0] RCW_READ      = 3'b101;
    localparam logic [2:0] RCW_WRITE     = 3'b100;
    localparam logic [2:0] RCW_PRECHARGE = 3'b010;

    typedef logic [PADDR_BITS-1:0]        paddr_t;
    typedef logic [COL_BITS-1:0]          col_t;
    typedef logic [BA_BITS-1:0]           bank_t;
    typedef logic [BG_BITS-1:0]           bank_group_t;
    typedef logic [ROW_BITS-1:0]          row_t;
    typedef logic [BG_BITS+BA_BITS-1:0]   bank_idx_t;  // {bank group, bank}
    typedef logic [DRAM_ADDR_BITS-1:0]    dram_addr_t;
    typedef logic [DATA_BITS-1:0]         data_t;
    typedef logic [WAIT_BITS-1:0]         wait_cnt_t;
    typedef logic [QPTR_BITS-1:0]         qptr_t;
    typedef logic [QPTR_BITS:0]           qcount_t;   // One extra bit to hold a full count

    // Decoded memory request, 81 bits
    typedef struct packed {
        logic        write;       // 1 = write, 0 = read
        bank_group_t bank_group;
        bank_t       bank;
        row_t        row;
        col_t        col;
        data_t       data;        // Only meaningful for writes
    } mem_request_t;

    // Command as driven to the DIMM, 86 bits
    typedef struct packed {
        logic        act_n;       // Low only for ACTIVATE
        bank_group_t bank_group;
        bank_t       bank;
        dram_addr_t  addr;        // Row for ACTIVATE, RAS/CAS/WE + column otherwise
        data_t       data;        // Write data, zero for other commands
    } dram_cmd_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PRE_WAIT,
        SEQ_ACT_WAIT
    } seq_state_e;

endpackage : dram_cmd_pkg

`default_nettype wire

// ==== source/dram_request_decoder.sv ====
// Request decoder
// Registers the request strobe and splits the physical address into DRAM fields
`timescale 1ns/1ps
`default_nettype none

module dram_request_decoder
    import dram_cmd_pkg::*;
(
    input  wire logic   clk_in,
    input  wire logic   rst_in,
    input  wire logic   req_valid_in,   // One-cycle request strobe
    input  wire logic   req_write_in,
    input  wire paddr_t req_addr_in,
    input  wire data_t  req_data_in,
    output logic         push,          // To FIFO, one cycle after the strobe
    output mem_request_t push_req
);

    mem_request_t decoded;

    // Address map, low to high: col, bank, bank group, row; top bits dropped
    always_comb begin
        decoded.write      = req_write_in;
        decoded.col        = req_addr_in[COL_BITS-1:0];
        decoded.bank       = req_addr_in[COL_BITS +: BA_BITS];
        decoded.bank_group = req_addr_in[COL_BITS+BA_BITS +: BG_BITS];
        decoded.row        = req_addr_in[COL_BITS+BA_BITS+BG_BITS +: ROW_BITS];
        decoded.data       = req_data_in;
    end

    // Strobe register
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            push <= 1'b0;
        end else begin
            push <= req_valid_in;
        end
    end

    // Request payload, only loaded on a strobe
    always_ff @(posedge clk_in) begin
        if (req_valid_in) begin
            push_req <= decoded;
        end
    end

endmodule : dram_request_decoder

`default_nettype wire

// ==== source/dram_request_fifo.sv ====
// Request FIFO
// In-order circular queue of decoded requests with full and empty flags
`timescale 1ns/1ps
`default_nettype none

module dram_request_fifo
    import dram_cmd_pkg::*;
(
    input  wire logic         clk_in,
    input  wire logic         rst_in,
    input  wire logic         push,
    input  wire mem_request_t push_req,
    input  wire logic         pop,      // Head leaves at the edge where pop is high
    output mem_request_t      head,
    output logic              empty,
    output logic              full
);

    mem_request_t mem [QUEUE_DEPTH];  // Entry storage
    qptr_t        rd_ptr;
    qptr_t        wr_ptr;
    qcount_t      count;
    logic         do_push;
    logic         do_pop;

    // Overflow guard lives here, producer never looks at full
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Flags straight from the count
    assign full  = (count == qcount_t'(QUEUE_DEPTH));
    assign empty = (count == '0);

    assign head = mem[rd_ptr];  // First-word fall-through

    // Pointers and occupancy
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + qptr_t'(1);  // Wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + qptr_t'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + qcount_t'(1);
                2'b01:   count <= count - qcount_t'(1);
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

endmodule : dram_request_fifo

`default_nettype wire

// ==== source/dram_command_sequencer.sv ====
// Command sequencer
// Tracks open rows per bank and turns each queued request into encoded DRAM commands
`timescale 1ns/1ps
`default_nettype none

module dram_command_sequencer
    import dram_cmd_pkg::*;
(
    input  wire logic         clk_in,
    input  wire logic         rst_in,
    input  wire mem_request_t head,   // Oldest queued request
    input  wire logic         empty,
    output logic              pop,    // Combinational, same cycle the access is decided
    output logic              cmd_valid,
    output dram_cmd_t         cmd
);

    seq_state_e            state;
    wait_cnt_t             wait_cnt;
    logic [NUM_BANKS-1:0]  bank_open;            // One bit per bank
    row_t                  open_row [NUM_BANKS]; // Row held in each row buffer

    bank_idx_t idx;
    logic      idle_go;
    logic      wait_done;
    logic      row_hit;
    logic      issue_act;
    logic      issue_pre;
    logic      issue_access;
    dram_cmd_t cmd_next;

    // ACTIVATE carries the zero-padded row
    function automatic dram_cmd_t activate_cmd(input mem_request_t req);
        dram_cmd_t c;
        c.act_n      = 1'b0;
        c.bank_group = req.bank_group;
        c.bank       = req.bank;
        c.addr       = dram_addr_t'(req.row);
        c.data       = '0;
        return c;
    endfunction

    // Non-activate commands, RAS/CAS/WE on top and the column at the bottom
    function automatic dram_cmd_t pin_cmd(input mem_request_t req, input logic [2:0] rcw);
        dram_cmd_t c;
        c.act_n      = 1'b1;
        c.bank_group = req.bank_group;
        c.bank       = req.bank;
        c.addr       = {rcw, {(DRAM_ADDR_BITS-3-COL_BITS){1'b0}}, req.col};
        c.data       = (rcw == RCW_WRITE) ? req.data : '0;  // Data rides with WRITE only
        return c;
    endfunction

    assign idx       = {head.bank_group, head.bank};
    assign idle_go   = (state == SEQ_IDLE) && !empty;
    assign wait_done = (wait_cnt == '0);
    assign row_hit   = bank_open[idx] && (open_row[idx] == head.row);

    // Hit goes straight to the access, otherwise the ACT/PRE path is taken
    assign issue_access = (idle_go && row_hit) || ((state == SEQ_ACT_WAIT) && wait_done);
    assign issue_act    = (idle_go && !bank_open[idx]) || ((state == SEQ_PRE_WAIT) && wait_done);
    assign issue_pre    = idle_go && bank_open[idx] && !row_hit;  // Conflict

    assign pop = issue_access;  // Request retires with its READ/WRITE

    // Command encoding
    always_comb begin
        if (issue_act) begin
            cmd_next = activate_cmd(head);
        end else if (issue_pre) begin
            cmd_next = pin_cmd(head, RCW_PRECHARGE);
        end else begin
            cmd_next = pin_cmd(head, head.write ? RCW_WRITE : RCW_READ);
        end
    end

    // FSM, wait counter, open flags and command strobe
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state     <= SEQ_IDLE;
            wait_cnt  <= '0;
            bank_open <= '0;  // All banks closed
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= issue_access || issue_act || issue_pre;

            if (issue_act) begin
                bank_open[idx] <= 1'b1;
            end else if (issue_pre) begin
                bank_open[idx] <= 1'b0;
            end

            case (state)
                SEQ_IDLE: begin
                    if (issue_act) begin
                        state    <= SEQ_ACT_WAIT;
                        wait_cnt <= wait_cnt_t'(ACTIVATION_LATENCY - 1);
                    end else if (issue_pre) begin
                        state    <= SEQ_PRE_WAIT;
                        wait_cnt <= wait_cnt_t'(PRECHARGE_LATENCY - 1);
                    end
                end
                SEQ_PRE_WAIT: begin
                    if (wait_done) begin  // ACTIVATE goes out this edge
                        state    <= SEQ_ACT_WAIT;
                        wait_cnt <= wait_cnt_t'(ACTIVATION_LATENCY - 1);
                    end else begin
                        wait_cnt <= wait_cnt - wait_cnt_t'(1);
                    end
                end
                SEQ_ACT_WAIT: begin
                    if (wait_done) begin  // READ/WRITE goes out this edge
                        state <= SEQ_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - wait_cnt_t'(1);
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Row record and command payload
    always_ff @(posedge clk_in) begin
        if (issue_act) begin
            open_row[idx] <= head.row;
        end
        if (issue_access || issue_act || issue_pre) begin
            cmd <= cmd_next;
        end
    end

endmodule : dram_command_sequencer

`default_nettype wire

// ==== source/dram_cmd_frontend.sv ====
// DDR4 command front end top level
// Decoder feeds the in-order request FIFO, sequencer drains it into DRAM commands
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_frontend
    import dram_cmd_pkg::*;
(
    input  wire logic   clk_in,
    input  wire logic   rst_in,
    input  wire logic   req_valid_in,
    input  wire logic   req_write_in,
    input  wire paddr_t req_addr_in,
    input  wire data_t  req_data_in,
    output logic        queue_full,   // Caller must hold off strobes while high
    output logic        cmd_valid,
    output dram_cmd_t   cmd
);

    logic         push;
    mem_request_t push_req;
    logic         pop;
    mem_request_t head;
    logic         empty;

    dram_request_decoder u_decoder (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .req_valid_in (req_valid_in),
        .req_write_in (req_write_in),
        .req_addr_in  (req_addr_in),
        .req_data_in  (req_data_in),
        .push         (push),
        .push_req     (push_req)
    );

    dram_request_fifo u_fifo (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (queue_full)
    );

    dram_command_sequencer u_sequencer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

endmodule : dram_cmd_frontend

`default_nettype wire

// ==== bench/dram_cmd_frontend_props.sv ====
// Sequencer properties
// Reset state, pop safety, command encoding and DRAM wait timing
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_frontend_props
    import dram_cmd_pkg::*;
(
    input wire logic      clk_in,
    input wire logic      rst_in,
    input wire logic      empty,
    input wire logic      pop,
    input wire logic      cmd_valid,
    input wire dram_cmd_t cmd,
    input wire seq_state_e state
);

    logic is_pre;
    logic is_act;
    logic is_access;

    assign is_pre    = cmd_valid && cmd.act_n && (cmd.addr[16:14] == RCW_PRECHARGE);
    assign is_act    = cmd_valid && !cmd.act_n;
    assign is_access = cmd_valid && cmd.act_n && (cmd.addr[16:15] == 2'b10);  // READ or WRITE

    reset_quiet: assert property (@(posedge clk_in) rst_in |-> !cmd_valid && state == SEQ_IDLE)
        else $error("cmd_valid or state active during reset");

    pop_not_empty: assert property (@(posedge clk_in) disable iff (rst_in) pop |-> !empty)
        else $error("pop while FIFO empty");

    // Only ACTIVATE drops act_n, and it always starts the activate wait
    act_encoding: assert property (@(posedge clk_in) disable iff (rst_in)
        is_act |-> (state == SEQ_ACT_WAIT) && (cmd.addr[16:8] == '0))
        else $error("act_n low outside ACTIVATE");

    // PRECHARGE opens the precharge wait, an access leaves the FSM idle
    pin_encoding: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && cmd.act_n) |->
            (is_pre && state == SEQ_PRE_WAIT) || (is_access && state == SEQ_IDLE))
        else $error("RAS/CAS/WE code does not match the FSM step");

    pre_to_act: assert property (@(posedge clk_in) disable iff (rst_in)
        is_pre |-> ##PRECHARGE_LATENCY is_act)
        else $error("precharge to activate gap wrong");

    act_to_access: assert property (@(posedge clk_in) disable iff (rst_in)
        is_act |-> ##ACTIVATION_LATENCY is_access)
        else $error("activate to access gap wrong");

endmodule : dram_cmd_frontend_props

bind dram_command_sequencer dram_cmd_frontend_props u_props (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .empty     (empty),
    .pop       (pop),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .state     (state)
);

`default_nettype wire

// ==== bench/dram_cmd_frontend_tb.sv ====
// DDR4 command front end testbench
// Directed tests against a reference model of the address map, bank rules and encoding
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_frontend_tb
    import dram_cmd_pkg::*;
();

    // Cycle budgets per test, summed for the watchdog with a 2x margin
    localparam int WATCHDOG_CYCLES = (40 + 40 + 50 + 20 * 20 + 18 * 20 + 80) * 2;

    logic      clk_in;
    logic      rst_in;
    logic      req_valid_in;
    logic      req_write_in;
    paddr_t    req_addr_in;
    data_t     req_data_in;
    logic      queue_full;
    logic      cmd_valid;
    dram_cmd_t cmd;

    int        cycle = 0;
    int        errors = 0;
    int        tests = 0;
    int        checks = 0;
    int        checked = 0;        // Commands already compared
    int        strobe_cycle;
    integer    seed = 32'hde1c;

    dram_cmd_t exp_q [$];          // Model output
    int        exp_gap [$];        // Gap to previous command, -1 when not fixed
    dram_cmd_t got_q [$];          // Captured from the DUT
    int        got_cyc [$];

    logic      m_open [NUM_BANKS]; // Model open-row record
    row_t      m_row [NUM_BANKS];

    dram_cmd_frontend UUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle <= cycle + 1;

    // Capture on the falling edge where cmd and cmd_valid are stable
    always @(negedge clk_in) begin
        if (cmd_valid) begin
            got_q.push_back(cmd);
            got_cyc.push_back(cycle);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    task automatic step();
        @(posedge clk_in);
        #2;
    endtask

    task automatic check_cmd(input string name, input dram_cmd_t exp, input dram_cmd_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_gap(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic dram_cmd_t make_cmd(input logic act_n, input bank_group_t bg,
                                           input bank_t ba, input dram_addr_t a, input data_t d);
        dram_cmd_t c;
        c.act_n      = act_n;
        c.bank_group = bg;
        c.bank       = ba;
        c.addr       = a;
        c.data       = d;
        return c;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < NUM_BANKS; i++) begin
            m_open[i] = 1'b0;
            m_row[i]  = '0;
        end
    endtask

    // Address map: col [3:0], bank [5:4], bank group [7:6], row [15:8]
    task automatic model_request(input logic wr, input paddr_t a, input data_t d,
                                 input int first_gap);
        col_t        col;
        bank_t       ba;
        bank_group_t bg;
        row_t        rw;
        int          bi;
        dram_cmd_t   acc;
        col = a[3:0];
        ba  = a[5:4];
        bg  = a[7:6];
        rw  = a[15:8];
        bi  = {bg, ba};
        acc = make_cmd(1'b1, bg, ba, {wr ? 3'b100 : 3'b101, 10'b0, col}, wr ? d : '0);
        if (m_open[bi] && m_row[bi] == rw) begin      // Row hit
            exp_q.push_back(acc);
            exp_gap.push_back(first_gap);
        end else begin
            if (m_open[bi]) begin                     // Conflict, precharge first
                exp_q.push_back(make_cmd(1'b1, bg, ba, {3'b010, 10'b0, col}, '0));
                exp_gap.push_back(first_gap);
                first_gap = PRECHARGE_LATENCY;
            end
            exp_q.push_back(make_cmd(1'b0, bg, ba, {9'b0, rw}, '0));
            exp_gap.push_back(first_gap);
            exp_q.push_back(acc);
            exp_gap.push_back(ACTIVATION_LATENCY);
        end
        m_open[bi] = 1'b1;
        m_row[bi]  = rw;
    endtask

    // Called at 2 ns after an edge, returns 2 ns after the sampling edge
    task automatic send_request(input logic wr, input paddr_t a, input data_t d);
        req_valid_in = 1'b1;
        req_write_in = wr;
        req_addr_in  = a;
        req_data_in  = d;
        step();
        strobe_cycle = cycle;
        req_valid_in = 1'b0;
    endtask

    task automatic wait_commands(input int n);
        while (got_q.size() < n) @(negedge clk_in);
    endtask

    task automatic compare_commands(input string name);
        wait_commands(exp_q.size());
        repeat (3) step();                            // Nothing extra may follow
        check_gap({name, " command count"}, exp_q.size(), got_q.size());
        for (int i = checked; i < exp_q.size() && i < got_q.size(); i++) begin
            check_cmd($sformatf("%s cmd %0d", name, i), exp_q[i], got_q[i]);
            if (exp_gap[i] >= 0 && i > 0) begin
                check_gap($sformatf("%s gap %0d", name, i), exp_gap[i],
                          got_cyc[i] - got_cyc[i-1]);
            end
        end
        checked = exp_q.size();
    endtask

    task automatic report(input string name, input int start_errors);
        tests++;
        $display("%s: %s", name, (errors == start_errors) ? "passed" : "failed");
    endtask

    task automatic apply_reset();
        rst_in = 1'b1;
        repeat (3) step();
        rst_in = 1'b0;
        exp_q.delete();
        exp_gap.delete();
        got_q.delete();
        got_cyc.delete();
        checked = 0;
        model_reset();
    endtask

    task automatic test_closed_read();
        int e0 = errors;
        int base = got_q.size();
        paddr_t a = {3'b0, 8'h3c, 2'd1, 2'd2, 4'd5};
        send_request(1'b0, a, '0);
        model_request(1'b0, a, '0, -1);
        wait_commands(base + 1);
        check_gap("closed read latency", 2, got_cyc[base] - strobe_cycle);
        compare_commands("closed read");
        report("closed read", e0);
    endtask

    task automatic test_row_hits();
        int e0 = errors;
        paddr_t a;
        data_t d;
        for (int i = 0; i < 4; i++) begin             // Back to back strobes
            a = {3'b0, 8'h3c, 2'd1, 2'd2, 4'(9 + i)};
            d = {$random(seed), $random(seed)};
            send_request(1'b1, a, d);
            model_request(1'b1, a, d, (i == 0) ? -1 : 1);
        end
        compare_commands("row hits");
        report("row hits", e0);
    endtask

    task automatic test_row_conflict();
        int e0 = errors;
        paddr_t a = {3'b0, 8'h3d, 2'd1, 2'd2, 4'd3};
        send_request(1'b0, a, '0);
        model_request(1'b0, a, '0, -1);
        compare_commands("row conflict");
        report("row conflict", e0);
    endtask

    task automatic test_random_traffic();
        int e0 = errors;
        logic [31:0] r;
        paddr_t a;
        data_t d;
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            a = {r[18:16], 8'h3c + {6'b0, r[9:8]}, r[7:0]};  // Few rows, top bits ignored
            d = {$random(seed), $random(seed)};
            while (queue_full) step();
            send_request(r[31], a, d);
            model_request(r[31], a, d, -1);
            repeat (2) step();
        end
        compare_commands("random traffic");
        report("random traffic", e0);
    endtask

    task automatic test_queue_full();
        int e0 = errors;
        paddr_t a;
        a = {3'b0, 8'h10, 2'd2, 2'd1, 4'd0};
        send_request(1'b0, a, '0);                    // Open the row first
        model_request(1'b0, a, '0, -1);
        compare_commands("queue full setup");
        for (int i = 0; i < 17; i++) begin            // One conflict and 16 behind it
            a = {3'b0, (i % 2 == 0) ? 8'h11 : 8'h10, 2'd2, 2'd1, 4'(i)};
            send_request(1'b0, a, '0);
            model_request(1'b0, a, '0, -1);
        end
        step();
        check_flag("queue full raised", 1'b1, queue_full);
        compare_commands("queue full");
        check_flag("queue full cleared", 1'b0, queue_full);
        report("queue full", e0);
    endtask

    task automatic test_reset_midrun();
        int e0 = errors;
        row_t keep_row = m_row[4'b1001];              // Bank group 2, bank 1
        paddr_t a = {3'b0, 8'h77, 2'd0, 2'd0, 4'd1};
        send_request(1'b0, a, '0);
        wait_commands(got_q.size() + 1);
        step();
        apply_reset();
        a = {3'b0, keep_row, 2'd2, 2'd1, 4'd6};
        send_request(1'b0, a, '0);
        model_request(1'b0, a, '0, -1);
        compare_commands("reset midrun");
        check_flag("activate after reset", 1'b0, got_q[0].act_n);
        report("reset midrun", e0);
    endtask

    initial begin
        rst_in       = 1'b1;
        req_valid_in = 1'b0;
        req_write_in = 1'b0;
        req_addr_in  = '0;
        req_data_in  = '0;
        model_reset();
        apply_reset();
        check_flag("cmd_valid after reset", 1'b0, cmd_valid);
        check_flag("queue_full after reset", 1'b0, queue_full);
        test_closed_read();
        test_row_hits();
        test_row_conflict();
        test_random_traffic();
        test_queue_full();
        test_reset_midrun();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : dram_cmd_frontend_tb

`default_nettype wire

// ==== vlog.f ====
source/dram_cmd_pkg.sv
source/dram_request_decoder.sv
source/dram_request_fifo.sv
source/dram_command_sequencer.sv
source/dram_cmd_frontend.sv
bench/dram_cmd_frontend_props.sv
bench/dram_cmd_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the DDR4 command front end testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module dram_cmd_frontend_tb \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
